//--- timer_pkg.sv
// timer package with register offsets, config word layout, widths and shared structs
`default_nettype none

package timer_pkg;

   // ******************************
   // widths
   // ******************************
   localparam int DATA_W    = 32;  // bus and counter width
   localparam int PRESC_W   = 8;   // prescaler compare field
   localparam int REG_OFF_W = 6;   // decoded address bits

   // ******************************
   // register offsets
   // ******************************
   localparam logic [REG_OFF_W-1:0] CFG_LO   = 6'h00;
   localparam logic [REG_OFF_W-1:0] CFG_HI   = 6'h04;
   localparam logic [REG_OFF_W-1:0] VAL_LO   = 6'h08;
   localparam logic [REG_OFF_W-1:0] VAL_HI   = 6'h0C;
   localparam logic [REG_OFF_W-1:0] CMP_LO   = 6'h10;
   localparam logic [REG_OFF_W-1:0] CMP_HI   = 6'h14;
   localparam logic [REG_OFF_W-1:0] START_LO = 6'h18;  // write-only strobe
   localparam logic [REG_OFF_W-1:0] START_HI = 6'h1C;  // write-only strobe
   localparam logic [REG_OFF_W-1:0] RESET_LO = 6'h20;  // write-only strobe
   localparam logic [REG_OFF_W-1:0] RESET_HI = 6'h24;  // write-only strobe

   // one configuration word, msb first
   typedef struct packed {
      logic [15:0]        rsvd_hi;    // bits 31..16
      logic [PRESC_W-1:0] presc_cmp;  // bits 15..8
      logic               rsvd;       // bit 7 reserved
      logic               presc_en;
      logic               one_shot;
      logic               cmp_clr;
      logic               event_en;
      logic               irq_en;
      logic               reset;      // self clearing
      logic               enable;     // bit 0
   } timer_cfg_t;

   // apb request as seen by the register block
   typedef struct packed {
      logic [REG_OFF_W-1:0] paddr;
      logic [DATA_W-1:0]    pwdata;
      logic                 pwrite;
      logic                 psel;
      logic                 penable;
   } apb_req_t;

   // single cycle strobes towards one channel
   typedef struct packed {
      logic              start;
      logic              reset;
      logic              load;        // counter value write
      logic [DATA_W-1:0] load_value;
   } chan_ctrl_t;

endpackage

`default_nettype wire

//--- timer_counter.sv
// timer_counter: up counter with clear, load, enable and equality compare
`timescale 1ns/100ps
`default_nettype none

module timer_counter
(
   input  logic                        HCLK,
   input  logic                        HRESETn,

   input  logic                        load_i,
   input  logic [timer_pkg::DATA_W-1:0] load_value_i,

   input  logic                        enable_i,
   input  logic                        clear_i,
   input  logic [timer_pkg::DATA_W-1:0] compare_i,

   output logic [timer_pkg::DATA_W-1:0] value_o,
   output logic                        match_o
);

   logic [timer_pkg::DATA_W-1:0] count_q;

   // ******************************
   // counter register
   // ******************************
   // clear beats load, load beats increment
   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         count_q <= '0;
      end
      else if (clear_i)
      begin
         count_q <= '0;
      end
      else if (load_i)
      begin
         count_q <= load_value_i;  // bus write of the value
      end
      else if (enable_i)
      begin
         count_q <= count_q + 1'b1;
      end
   end

   assign value_o = count_q;

   // only flags a match on a cycle that actually counts
   assign match_o = enable_i && (count_q == compare_i);

endmodule

`default_nettype wire

//--- timer_channel.sv
// timer_channel: enable and clear control, prescaler counter and main counter
`timescale 1ns/100ps
`default_nettype none

module timer_channel
(
   input  logic                         HCLK,
   input  logic                         HRESETn,

   input  timer_pkg::timer_cfg_t        cfg_i,
   input  logic [timer_pkg::DATA_W-1:0] cmp_i,
   input  timer_pkg::chan_ctrl_t        ctrl_i,
   input  logic                         stop_i,

   output logic [timer_pkg::DATA_W-1:0] value_o,
   output logic                         target_reached_o
);

   logic                         run;          // enabled and not frozen
   logic                         presc_en;
   logic                         presc_wrap;
   logic                         presc_clear;
   logic [timer_pkg::DATA_W-1:0] presc_cmp;
   logic                         count_en;
   logic                         count_clear;
   logic                         clear_all;

   // ******************************
   // enables
   // ******************************
   assign run      = cfg_i.enable & ~stop_i;
   assign presc_en = run & cfg_i.presc_en;

   always_comb
   begin
      if (cfg_i.presc_en)
      begin
         count_en = presc_wrap;  // one step per prescaler period
      end
      else
      begin
         count_en = run;
      end
   end

   // ******************************
   // clears
   // ******************************
   // reset bit and reset strobe both hit the two counters
   assign clear_all = cfg_i.reset | ctrl_i.reset;

   // a start strobe also realigns the prescaler phase
   assign presc_clear = clear_all | presc_wrap | ctrl_i.start;
   assign count_clear = clear_all | (cfg_i.cmp_clr & target_reached_o);

   assign presc_cmp = {{(timer_pkg::DATA_W - timer_pkg::PRESC_W){1'b0}}, cfg_i.presc_cmp};

   // ******************************
   // counters
   // ******************************
   timer_counter u_presc
   (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .load_i       (1'b0),
      .load_value_i ('0),
      .enable_i     (presc_en),
      .clear_i      (presc_clear),
      .compare_i    (presc_cmp),
      .value_o      (),
      .match_o      (presc_wrap)
   );

   timer_counter u_count
   (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .load_i       (ctrl_i.load),
      .load_value_i (ctrl_i.load_value),
      .enable_i     (count_en),
      .clear_i      (count_clear),
      .compare_i    (cmp_i),
      .value_o      (value_o),
      .match_o      (target_reached_o)  // already qualified by count_en
   );

endmodule

`default_nettype wire

//--- timer_regs.sv
// timer_regs: apb decode, config and compare registers, strobes and read mux
`timescale 1ns/100ps
`default_nettype none

module timer_regs
(
   input  logic                         HCLK,
   input  logic                         HRESETn,

   input  timer_pkg::apb_req_t          apb_i,

   input  logic                         event_lo_i,
   input  logic                         event_hi_i,
   input  logic [timer_pkg::DATA_W-1:0] value_lo_i,
   input  logic [timer_pkg::DATA_W-1:0] value_hi_i,
   input  logic                         reached_lo_i,
   input  logic                         reached_hi_i,

   output timer_pkg::timer_cfg_t        cfg_lo_o,
   output timer_pkg::timer_cfg_t        cfg_hi_o,
   output logic [timer_pkg::DATA_W-1:0] cmp_lo_o,
   output logic [timer_pkg::DATA_W-1:0] cmp_hi_o,
   output timer_pkg::chan_ctrl_t        ctrl_lo_o,
   output timer_pkg::chan_ctrl_t        ctrl_hi_o,

   output logic [timer_pkg::DATA_W-1:0] prdata_o,
   output logic                         pready_o
);

   logic                         access;
   logic                         wr_en;
   logic                         rd_en;

   timer_pkg::timer_cfg_t        cfg_lo_q, cfg_hi_q;
   timer_pkg::timer_cfg_t        cfg_lo_wr, cfg_hi_wr;  // after bus write only
   timer_pkg::timer_cfg_t        cfg_lo_d, cfg_hi_d;
   logic [timer_pkg::DATA_W-1:0] cmp_lo_q, cmp_hi_q;
   logic [timer_pkg::DATA_W-1:0] cmp_lo_d, cmp_hi_d;

   // start/event set enable over bus write and one-shot clear
   function automatic timer_pkg::timer_cfg_t apply_rules(
      input timer_pkg::timer_cfg_t cfg_q,
      input timer_pkg::timer_cfg_t cfg_wr,
      input logic                  start,
      input logic                  evt,
      input logic                  reached
   );
      timer_pkg::timer_cfg_t cfg_n;

      cfg_n         = cfg_wr;
      cfg_n.rsvd    = 1'b0;
      cfg_n.rsvd_hi = '0;
      if (start || (evt && cfg_wr.event_en))
      begin
         cfg_n.enable = 1'b1;
      end
      else if (cfg_wr.one_shot && reached)
      begin
         cfg_n.enable = 1'b0;  // halt once target is hit
      end
      if (cfg_q.reset)
      begin
         cfg_n.reset = 1'b0;   // reset bit lives for one cycle
      end
      return cfg_n;
   endfunction

   // zero wait, no error
   assign access   = apb_i.psel & apb_i.penable;
   assign wr_en    = access & apb_i.pwrite;
   assign rd_en    = access & ~apb_i.pwrite;
   assign pready_o = access;

   // ******************************
   // write decode
   // ******************************
   always_comb
   begin
      cfg_lo_wr = cfg_lo_q;
      cfg_hi_wr = cfg_hi_q;
      cmp_lo_d  = cmp_lo_q;
      cmp_hi_d  = cmp_hi_q;
      ctrl_lo_o = '{start: 1'b0, reset: 1'b0, load: 1'b0, load_value: apb_i.pwdata};
      ctrl_hi_o = '{start: 1'b0, reset: 1'b0, load: 1'b0, load_value: apb_i.pwdata};

      if (wr_en)
      begin
         case (apb_i.paddr)
            timer_pkg::CFG_LO:   cfg_lo_wr       = apb_i.pwdata;
            timer_pkg::CFG_HI:   cfg_hi_wr       = apb_i.pwdata;
            timer_pkg::VAL_LO:   ctrl_lo_o.load  = 1'b1;
            timer_pkg::VAL_HI:   ctrl_hi_o.load  = 1'b1;
            timer_pkg::CMP_LO:   cmp_lo_d        = apb_i.pwdata;
            timer_pkg::CMP_HI:   cmp_hi_d        = apb_i.pwdata;
            timer_pkg::START_LO: ctrl_lo_o.start = 1'b1;
            timer_pkg::START_HI: ctrl_hi_o.start = 1'b1;
            timer_pkg::RESET_LO: ctrl_lo_o.reset = 1'b1;
            timer_pkg::RESET_HI: ctrl_hi_o.reset = 1'b1;
            default: ;           // unmapped, ignored
         endcase
      end

      cfg_lo_d = apply_rules(cfg_lo_q, cfg_lo_wr, ctrl_lo_o.start, event_lo_i, reached_lo_i);
      cfg_hi_d = apply_rules(cfg_hi_q, cfg_hi_wr, ctrl_hi_o.start, event_hi_i, reached_hi_i);
   end

   always_ff @(posedge HCLK, negedge HRESETn)
   begin
      if (!HRESETn)
      begin
         cfg_lo_q <= '0;
         cfg_hi_q <= '0;
         cmp_lo_q <= '0;
         cmp_hi_q <= '0;
      end
      else
      begin
         cfg_lo_q <= cfg_lo_d;
         cfg_hi_q <= cfg_hi_d;
         cmp_lo_q <= cmp_lo_d;
         cmp_hi_q <= cmp_hi_d;
      end
   end

   assign cfg_lo_o = cfg_lo_q;
   assign cfg_hi_o = cfg_hi_q;
   assign cmp_lo_o = cmp_lo_q;
   assign cmp_hi_o = cmp_hi_q;

   // ******************************
   // read mux
   // ******************************
   always_comb
   begin
      prdata_o = '0;
      if (rd_en)
      begin
         case (apb_i.paddr)
            timer_pkg::CFG_LO: prdata_o = cfg_lo_q;
            timer_pkg::CFG_HI: prdata_o = cfg_hi_q;
            timer_pkg::VAL_LO: prdata_o = value_lo_i;
            timer_pkg::VAL_HI: prdata_o = value_hi_i;
            timer_pkg::CMP_LO: prdata_o = cmp_lo_q;
            timer_pkg::CMP_HI: prdata_o = cmp_hi_q;
            default:           prdata_o = '0;  // strobes and holes read 0
         endcase
      end
   end

endmodule

`default_nettype wire

//--- apb_timer_unit.sv
// apb_timer_unit: top level with register block, two timer channels, irq and busy
`timescale 1ns/100ps
`default_nettype none

module apb_timer_unit
#(
   parameter int ADDR_W = 12
)
(
   input  logic                         HCLK,
   input  logic                         HRESETn,

   // apb slave
   input  logic [ADDR_W-1:0]            PADDR,
   input  logic [timer_pkg::DATA_W-1:0] PWDATA,
   input  logic                         PWRITE,
   input  logic                         PSEL,
   input  logic                         PENABLE,
   output logic [timer_pkg::DATA_W-1:0] PRDATA,
   output logic                         PREADY,
   output logic                         PSLVERR,

   input  logic                         event_lo_i,
   input  logic                         event_hi_i,
   input  logic                         stoptimer_i,  // freezes both channels

   output logic                         irq_lo_o,
   output logic                         irq_hi_o,
   output logic                         busy_o
);

   timer_pkg::apb_req_t          apb_req;
   timer_pkg::timer_cfg_t        cfg_lo, cfg_hi;
   timer_pkg::chan_ctrl_t        ctrl_lo, ctrl_hi;
   logic [timer_pkg::DATA_W-1:0] cmp_lo, cmp_hi;
   logic [timer_pkg::DATA_W-1:0] value_lo, value_hi;
   logic                         reached_lo, reached_hi;

   // only the low offset bits are decoded
   assign apb_req.paddr   = PADDR[timer_pkg::REG_OFF_W-1:0];
   assign apb_req.pwdata  = PWDATA;
   assign apb_req.pwrite  = PWRITE;
   assign apb_req.psel    = PSEL;
   assign apb_req.penable = PENABLE;

   assign PSLVERR = 1'b0;

   timer_regs u_regs
   (
      .HCLK         (HCLK),
      .HRESETn      (HRESETn),
      .apb_i        (apb_req),
      .event_lo_i   (event_lo_i),
      .event_hi_i   (event_hi_i),
      .value_lo_i   (value_lo),
      .value_hi_i   (value_hi),
      .reached_lo_i (reached_lo),
      .reached_hi_i (reached_hi),
      .cfg_lo_o     (cfg_lo),
      .cfg_hi_o     (cfg_hi),
      .cmp_lo_o     (cmp_lo),
      .cmp_hi_o     (cmp_hi),
      .ctrl_lo_o    (ctrl_lo),
      .ctrl_hi_o    (ctrl_hi),
      .prdata_o     (PRDATA),
      .pready_o     (PREADY)
   );

   // ******************************
   // channels
   // ******************************
   timer_channel u_chan_lo
   (
      .HCLK             (HCLK),
      .HRESETn          (HRESETn),
      .cfg_i            (cfg_lo),
      .cmp_i            (cmp_lo),
      .ctrl_i           (ctrl_lo),
      .stop_i           (stoptimer_i),
      .value_o          (value_lo),
      .target_reached_o (reached_lo)
   );

   timer_channel u_chan_hi
   (
      .HCLK             (HCLK),
      .HRESETn          (HRESETn),
      .cfg_i            (cfg_hi),
      .cmp_i            (cmp_hi),
      .ctrl_i           (ctrl_hi),
      .stop_i           (stoptimer_i),
      .value_o          (value_hi),
      .target_reached_o (reached_hi)
   );

   // irq follows the match in the same cycle
   assign irq_lo_o = reached_lo & cfg_lo.irq_en;
   assign irq_hi_o = reached_hi & cfg_hi.irq_en;
   assign busy_o   = cfg_lo.enable | cfg_hi.enable;

endmodule

`default_nettype wire

//--- tb_apb_timer_tasks.svh
// apb access tasks, value check, irq wait helpers and the directed tests
`ifndef TB_APB_TIMER_TASKS_SVH
`define TB_APB_TIMER_TASKS_SVH

task automatic compare_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
   if (actual !== expected)
   begin
      $display("** Error at %0t ns: %s = 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "value mismatch");
   end
endtask

// ******************************
// apb access
// ******************************
task automatic apb_write(input logic [timer_pkg::REG_OFF_W-1:0] off, input logic [31:0] data);
   @(posedge HCLK);
   PADDR   <= ADDR_W'(off);
   PWDATA  <= data;
   PWRITE  <= 1'b1;
   PSEL    <= 1'b1;
   PENABLE <= 1'b0;  // setup phase
   @(posedge HCLK);
   PENABLE <= 1'b1;
   @(posedge HCLK);  // register updates on this edge
   PSEL    <= 1'b0;
   PENABLE <= 1'b0;
   PWRITE  <= 1'b0;
endtask

task automatic apb_read(input logic [timer_pkg::REG_OFF_W-1:0] off, output logic [31:0] data);
   @(posedge HCLK);
   PADDR   <= ADDR_W'(off);
   PWRITE  <= 1'b0;
   PSEL    <= 1'b1;
   PENABLE <= 1'b0;
   @(negedge HCLK);
   compare_value("PREADY", 32'(PREADY), 32'd0);  // not ready in setup
   @(posedge HCLK);
   PENABLE <= 1'b1;
   @(negedge HCLK);
   compare_value("PREADY", 32'(PREADY), 32'd1);
   compare_value("PSLVERR", 32'(PSLVERR), 32'd0);
   data = PRDATA;
   @(posedge HCLK);
   PSEL    <= 1'b0;
   PENABLE <= 1'b0;
endtask

task automatic read_expect(input logic [timer_pkg::REG_OFF_W-1:0] off, input string name,
                           input logic [31:0] expected);
   logic [31:0] data;
   apb_read(off, data);
   compare_value(name, data, expected);
endtask

// counts falling edges until the chosen irq is high
task automatic wait_irq(input logic hi_chan, input int unsigned limit,
                        output int unsigned cycles);
   cycles = 0;
   do
   begin
      @(negedge HCLK);
      cycles++;
      if (cycles > limit)
      begin
         $display("irq %s did not arrive within %0d cycles", hi_chan ? "hi" : "lo", limit);
         $display("Errors found");
         $fatal(1, "irq timeout");
      end
   end
   while ((hi_chan ? irq_hi_o : irq_lo_o) !== 1'b1);
endtask

task automatic check_irq_period(input int unsigned period);
   int unsigned cycles;
   wait_irq(1'b0, 2 * period + 10, cycles);  // phase of the first pulse is free
   repeat (2)
   begin
      @(negedge HCLK);
      compare_value("irq_lo_o width", 32'(irq_lo_o), 32'd0);
      wait_irq(1'b0, 2 * period, cycles);
      compare_value("irq_lo_o period", cycles + 1, period);
   end
endtask

task automatic start_lo(input logic [31:0] cmp, input timer_pkg::timer_cfg_t cfg);
   apb_write(timer_pkg::CFG_LO, 32'd0);
   apb_write(timer_pkg::RESET_LO, 32'd0);
   apb_write(timer_pkg::CMP_LO, cmp);
   apb_write(timer_pkg::CFG_LO, cfg);
   apb_write(timer_pkg::START_LO, 32'd0);
endtask

// ******************************
// directed tests
// ******************************
task automatic check_reset_state();
   logic [31:0] cmp_lo_val;
   logic [31:0] cmp_hi_val;
   @(negedge HCLK);
   compare_value("irq_lo_o", 32'(irq_lo_o), 32'd0);
   compare_value("irq_hi_o", 32'(irq_hi_o), 32'd0);
   compare_value("busy_o", 32'(busy_o), 32'd0);
   compare_value("PREADY", 32'(PREADY), 32'd0);  // idle bus
   read_expect(timer_pkg::CFG_LO, "CFG_LO", 32'd0);
   read_expect(timer_pkg::CFG_HI, "CFG_HI", 32'd0);
   read_expect(timer_pkg::VAL_LO, "VAL_LO", 32'd0);
   read_expect(timer_pkg::VAL_HI, "VAL_HI", 32'd0);
   read_expect(timer_pkg::CMP_LO, "CMP_LO", 32'd0);
   read_expect(timer_pkg::CMP_HI, "CMP_HI", 32'd0);
   cmp_lo_val = $urandom;
   cmp_hi_val = $urandom;
   apb_write(timer_pkg::CMP_LO, cmp_lo_val);
   apb_write(timer_pkg::CMP_HI, cmp_hi_val);
   read_expect(timer_pkg::CMP_LO, "CMP_LO", cmp_lo_val);
   read_expect(timer_pkg::CMP_HI, "CMP_HI", cmp_hi_val);
   read_expect(timer_pkg::START_LO, "START_LO", 32'd0);  // strobes read 0
endtask

task automatic load_and_clear_value();
   logic [31:0] lo_val;
   logic [31:0] hi_val;
   lo_val = $urandom | 32'h1;
   hi_val = $urandom | 32'h1;
   apb_write(timer_pkg::VAL_LO, lo_val);
   apb_write(timer_pkg::VAL_HI, hi_val);
   read_expect(timer_pkg::VAL_LO, "VAL_LO", lo_val);
   read_expect(timer_pkg::VAL_HI, "VAL_HI", hi_val);
   apb_write(timer_pkg::RESET_LO, 32'd0);
   read_expect(timer_pkg::VAL_LO, "VAL_LO", 32'd0);
   read_expect(timer_pkg::VAL_HI, "VAL_HI", hi_val);  // hi channel untouched
   apb_write(timer_pkg::RESET_HI, 32'd0);
   read_expect(timer_pkg::VAL_HI, "VAL_HI", 32'd0);
endtask

task automatic freeze_on_stop();
   logic [31:0] frozen;
   logic [31:0] later;
   apb_write(timer_pkg::CMP_LO, 32'hFFFF_FFFF);  // keep clear of a match
   apb_write(timer_pkg::START_LO, 32'd0);
   repeat (5) @(posedge HCLK);
   stoptimer_i <= 1'b1;
   apb_read(timer_pkg::VAL_LO, frozen);
   apb_read(timer_pkg::VAL_LO, later);
   compare_value("VAL_LO", later, frozen);
   compare_value("VAL_LO nonzero", 32'(frozen != 32'd0), 32'd1);
   @(posedge HCLK);
   stoptimer_i <= 1'b0;
   apb_read(timer_pkg::VAL_LO, later);
   compare_value("VAL_LO advanced", 32'(later > frozen), 32'd1);
   apb_write(timer_pkg::CFG_LO, 32'd0);
endtask

task automatic periodic_irq();
   timer_pkg::timer_cfg_t cfg;
   int unsigned           n;
   n           = 3 + ($urandom % 6);
   cfg         = '0;
   cfg.irq_en  = 1'b1;
   cfg.cmp_clr = 1'b1;
   start_lo(n, cfg);
   check_irq_period(n + 1);  // counts 0..n
endtask

task automatic prescaled_irq();
   timer_pkg::timer_cfg_t cfg;
   int unsigned           n;
   int unsigned           p;
   n             = 3 + ($urandom % 6);
   p             = 1 + ($urandom % 4);
   cfg           = '0;
   cfg.irq_en    = 1'b1;
   cfg.cmp_clr   = 1'b1;
   cfg.presc_en  = 1'b1;
   cfg.presc_cmp = 8'(p);
   start_lo(n, cfg);
   check_irq_period((n + 1) * (p + 1));
   apb_write(timer_pkg::CFG_LO, 32'd0);
endtask

task automatic one_shot_event_start();
   timer_pkg::timer_cfg_t cfg;
   int unsigned           m;
   int unsigned           cycles;
   logic [31:0]           first;
   logic [31:0]           second;
   m            = 4 + ($urandom % 8);
   cfg          = '0;
   cfg.one_shot = 1'b1;
   cfg.event_en = 1'b1;
   cfg.irq_en   = 1'b1;
   apb_write(timer_pkg::RESET_HI, 32'd0);
   apb_write(timer_pkg::CMP_HI, m);
   apb_write(timer_pkg::CFG_HI, cfg);
   @(negedge HCLK);
   compare_value("busy_o", 32'(busy_o), 32'd0);
   @(posedge HCLK);
   event_hi_i <= 1'b1;
   @(posedge HCLK);
   event_hi_i <= 1'b0;
   @(negedge HCLK);
   compare_value("busy_o", 32'(busy_o), 32'd1);
   wait_irq(1'b1, m + 10, cycles);
   @(negedge HCLK);
   compare_value("irq_hi_o", 32'(irq_hi_o), 32'd0);
   compare_value("busy_o", 32'(busy_o), 32'd0);  // halted after the target
   repeat (m + 4)
   begin
      @(negedge HCLK);
      compare_value("irq_hi_o", 32'(irq_hi_o), 32'd0);
   end
   apb_read(timer_pkg::VAL_HI, first);
   apb_read(timer_pkg::VAL_HI, second);
   compare_value("VAL_HI", second, first);
endtask

`endif

//--- tb_apb_timer_unit.sv
// testbench top with clock, reset, DUT instance, watchdog and the directed test sequence
`timescale 1ns/100ps
`default_nettype none

module tb_apb_timer_unit;

   localparam int ADDR_W  = 12;
   localparam int CLK_PER = 4;   // ns

   // cycle budget of each directed test
   localparam int T_RESET    = 60;
   localparam int T_LOAD     = 40;
   localparam int T_STOP     = 50;
   localparam int T_PERIODIC = 70;
   localparam int T_PRESC    = 200;
   localparam int T_ONESHOT  = 70;
   localparam int T_MARGIN   = 100;
   localparam int WATCHDOG_CYCLES = 2 + T_RESET + T_LOAD + T_STOP + T_PERIODIC
                                    + T_PRESC + T_ONESHOT + T_MARGIN;

   logic              HCLK;
   logic              HRESETn;
   logic [ADDR_W-1:0] PADDR;
   logic [31:0]       PWDATA;
   logic              PWRITE;
   logic              PSEL;
   logic              PENABLE;
   logic [31:0]       PRDATA;
   logic              PREADY;
   logic              PSLVERR;
   logic              event_lo_i;
   logic              event_hi_i;
   logic              stoptimer_i;
   logic              irq_lo_o;
   logic              irq_hi_o;
   logic              busy_o;

`include "tb_apb_timer_tasks.svh"

   apb_timer_unit #(.ADDR_W(ADDR_W)) i_dut
   (
      .HCLK        (HCLK),
      .HRESETn     (HRESETn),
      .PADDR       (PADDR),
      .PWDATA      (PWDATA),
      .PWRITE      (PWRITE),
      .PSEL        (PSEL),
      .PENABLE     (PENABLE),
      .PRDATA      (PRDATA),
      .PREADY      (PREADY),
      .PSLVERR     (PSLVERR),
      .event_lo_i  (event_lo_i),
      .event_hi_i  (event_hi_i),
      .stoptimer_i (stoptimer_i),
      .irq_lo_o    (irq_lo_o),
      .irq_hi_o    (irq_hi_o),
      .busy_o      (busy_o)
   );

   // ******************************
   // clock and watchdog
   // ******************************
   initial
   begin
      HCLK = 1'b0;
      forever
      begin
         #(CLK_PER / 2) HCLK = ~HCLK;
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PER);
      $display("watchdog expired after %0d cycles, the test sequence hung", WATCHDOG_CYCLES);
      $display("Errors found");
      $fatal(1, "watchdog timeout");
   end

   // ******************************
   // test sequence
   // ******************************
   initial
   begin
      void'($urandom(82361));
      HRESETn     = 1'b0;
      PADDR       = '0;
      PWDATA      = '0;
      PWRITE      = 1'b0;
      PSEL        = 1'b0;
      PENABLE     = 1'b0;
      event_lo_i  = 1'b0;
      event_hi_i  = 1'b0;
      stoptimer_i = 1'b0;

      repeat (2) @(posedge HCLK);   // reset held for two cycles
      HRESETn <= 1'b1;

      check_reset_state();
      load_and_clear_value();
      freeze_on_stop();
      periodic_irq();
      prescaled_irq();
      one_shot_event_start();

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- apb_timer_unit.f
+incdir+.
timer_pkg.sv
timer_counter.sv
timer_channel.sv
timer_regs.sv
apb_timer_unit.sv
tb_apb_timer_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the apb timer testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM_BIN=tb_sim

verilator --binary --timing \
   -f apb_timer_unit.f \
   --top-module tb_apb_timer_unit \
   --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^No errors$" "$LOG"; then
   echo "PASS"
   exit 0
else
   echo "FAIL"
   exit 1
fi
